//--- source/spi_ctrl_pkg.sv
// spi_ctrl_pkg: apb register offsets, spi field widths, clock divider and rx fifo sizing
`default_nettype none

package spi_ctrl_pkg;

    // apb slave side
    localparam int apb_addr_w = 4;   // byte offsets 0x0 to 0xf
    localparam int apb_data_w = 32;

    localparam logic [apb_addr_w-1:0] reg_ctrl_off   = 4'h0;  // is_write, start, soft_reset
    localparam logic [apb_addr_w-1:0] reg_write_off  = 4'h4;  // write address and data
    localparam logic [apb_addr_w-1:0] reg_read_off   = 4'h8;  // burst count and start address
    localparam logic [apb_addr_w-1:0] reg_status_off = 4'hc;  // read only

    // chip side framing
    localparam int chip_addr_w = 7;  // 128 registers in the peripheral
    localparam int spi_byte_w  = 8;
    localparam int burst_len_w = 8;  // up to 255 bytes per burst

    // system clocks per spi_clk half period, one spi bit is 2 * clk_div clocks
    localparam int clk_div   = 2;
    localparam int clk_div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

    // receive fifo, depth must stay a power of two for pointer wrap
    localparam int rx_fifo_depth = 16;
    localparam int rx_fifo_aw    = 4;

endpackage

`default_nettype wire

//--- source/spi_apb_regs.sv
// spi_apb_regs: apb slave with ctrl, write, read setup registers, status view and sticky flags
`timescale 1ns/1ps
`default_nettype none

module spi_apb_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [spi_ctrl_pkg::apb_addr_w-1:0]  paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [spi_ctrl_pkg::apb_data_w-1:0]  pwdata,
    output logic [spi_ctrl_pkg::apb_data_w-1:0]  prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic                                 busy,
    input  logic                                 xfer_done,
    input  logic                                 done_was_write,
    input  logic [spi_ctrl_pkg::spi_byte_w-1:0]  last_rx_byte,
    output logic                                 cmd_start,
    output logic                                 soft_clear,
    output logic                                 is_write,
    output logic [spi_ctrl_pkg::chip_addr_w-1:0] wr_addr,
    output logic [spi_ctrl_pkg::spi_byte_w-1:0]  wr_data,
    output logic [spi_ctrl_pkg::chip_addr_w-1:0] rd_addr,
    output logic [spi_ctrl_pkg::burst_len_w-1:0] rd_count,
    output logic                                 write_complete,
    output logic                                 read_complete
);
    import spi_ctrl_pkg::*;

    logic access;      // apb access phase
    logic wr_access;
    logic addr_err;    // offset beyond STATUS
    logic ctrl_wr;
    logic start_busy;  // start request refused, engine still occupied
    logic start_ok;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign addr_err  = paddr > reg_status_off;
    assign ctrl_wr   = wr_access && (paddr == reg_ctrl_off);

    // cmd_start still high means the engine has not raised busy yet
    assign start_busy = ctrl_wr && pwdata[1] && (busy || cmd_start);
    assign start_ok   = ctrl_wr && pwdata[1] && !start_busy;

    assign pready  = access;  // zero wait states
    assign pslverr = access && (addr_err || start_busy ||
                                (pwrite && paddr == reg_status_off));

    // read mux, start and soft_reset always read back as 0
    always_comb begin
        prdata = '0;
        case (paddr)
            reg_ctrl_off:   prdata[0] = is_write;
            reg_write_off: begin
                prdata[8 +: chip_addr_w] = wr_addr;
                prdata[0 +: spi_byte_w]  = wr_data;
            end
            reg_read_off: begin
                prdata[8 +: burst_len_w] = rd_count;
                prdata[0 +: chip_addr_w] = rd_addr;
            end
            reg_status_off: begin
                prdata[0 +: spi_byte_w] = last_rx_byte;  // most recent burst byte
                prdata[8]               = write_complete;
                prdata[9]               = read_complete;
                prdata[10]              = busy;
            end
            default:        prdata = '0;
        endcase
    end

    // setup registers and the one-cycle command pulses
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_start  <= 1'b0;
            soft_clear <= 1'b0;
            is_write   <= 1'b0;
            wr_addr    <= '0;
            wr_data    <= '0;
            rd_addr    <= '0;
            rd_count   <= '0;
        end else begin
            cmd_start  <= start_ok;                     // high in the cycle after the write
            soft_clear <= ctrl_wr && pwdata[2] && !start_busy;
            if (ctrl_wr && !start_busy)
                is_write <= pwdata[0];                  // refused start leaves ctrl alone
            if (wr_access && paddr == reg_write_off) begin
                wr_addr <= pwdata[8 +: chip_addr_w];
                wr_data <= pwdata[0 +: spi_byte_w];
            end
            if (wr_access && paddr == reg_read_off) begin
                rd_count <= pwdata[8 +: burst_len_w];
                rd_addr  <= pwdata[0 +: chip_addr_w];
            end
        end
    end

    // sticky completion flags, cleared by the next accepted start
    always_ff @(posedge clk) begin
        if (reset) begin
            write_complete <= 1'b0;
            read_complete  <= 1'b0;
        end else if (start_ok) begin
            write_complete <= 1'b0;
            read_complete  <= 1'b0;
        end else if (xfer_done) begin
            if (done_was_write) write_complete <= 1'b1;
            else                read_complete  <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/spi_xfer_engine.sv
// spi_xfer_engine: mode 0 spi master for write frames and burst reads with fifo back-pressure
`timescale 1ns/1ps
`default_nettype none

module spi_xfer_engine (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 soft_clear,
    input  logic                                 cmd_start,
    input  logic                                 is_write,
    input  logic [spi_ctrl_pkg::chip_addr_w-1:0] wr_addr,
    input  logic [spi_ctrl_pkg::spi_byte_w-1:0]  wr_data,
    input  logic [spi_ctrl_pkg::chip_addr_w-1:0] rd_addr,
    input  logic [spi_ctrl_pkg::burst_len_w-1:0] rd_count,
    input  logic                                 fifo_full,
    input  logic                                 serial_in,
    output logic                                 busy,
    output logic                                 xfer_done,
    output logic                                 done_was_write,
    output logic [spi_ctrl_pkg::spi_byte_w-1:0]  last_rx_byte,
    output logic                                 rx_push,
    output logic [spi_ctrl_pkg::spi_byte_w-1:0]  rx_byte,
    output logic                                 spi_cs_n,
    output logic                                 spi_clk,
    output logic                                 serial_out
);
    import spi_ctrl_pkg::*;

    typedef enum logic [2:0] {st_idle, st_cmd, st_wr, st_rd, st_stall} state_t;

    state_t                 state;
    logic [clk_div_w-1:0]   div_cnt;     // clocks spent in the current half period
    logic [2:0]             bit_cnt;     // bit within the byte, msb first
    logic [spi_byte_w-1:0]  shift_out;
    logic [spi_byte_w-1:0]  shift_in;
    logic [spi_byte_w-1:0]  wr_hold;     // data byte, latched at start
    logic [burst_len_w-1:0] bytes_left;
    logic                   tail;        // frame is over, stall holds the closing cycle
    logic                   shifting;
    logic                   half_end;
    logic                   rise;
    logic                   fall;
    logic                   byte_end;
    logic                   last_rise;

    assign shifting  = state inside {st_cmd, st_wr, st_rd};
    assign half_end  = shifting && (div_cnt == clk_div_w'(clk_div - 1));
    assign rise      = half_end && !spi_clk;
    assign fall      = half_end && spi_clk;
    assign byte_end  = fall && (bit_cnt == 3'd7);             // last falling edge of a byte
    assign last_rise = rise && (state == st_rd) && (bit_cnt == 3'd7);

    assign busy         = state != st_idle;
    assign spi_cs_n     = state == st_idle;
    assign serial_out   = busy && shift_out[spi_byte_w-1];
    assign last_rx_byte = rx_byte;                             // status keeps the newest byte

    // sequencing, spi clock and strobes
    always_ff @(posedge clk) begin
        if (reset || soft_clear) begin
            state          <= st_idle;
            div_cnt        <= '0;
            spi_clk        <= 1'b0;
            bit_cnt        <= '0;
            tail           <= 1'b0;
            xfer_done      <= 1'b0;
            done_was_write <= 1'b0;
            rx_push        <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            rx_push   <= last_rise;                            // one clock after 8th rising edge
            if (half_end) begin
                div_cnt <= '0;
                spi_clk <= ~spi_clk;
            end else if (shifting) begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (fall)
                bit_cnt <= bit_cnt + 1'b1;                     // wraps to 0 at byte end
            case (state)
                st_idle: if (cmd_start) begin
                    done_was_write <= is_write;                // transfer type for the flags
                    if (is_write || rd_count != '0)
                        state <= st_cmd;
                    else
                        xfer_done <= 1'b1;                     // empty burst ends at once
                end
                st_cmd: if (byte_end) begin
                    if (done_was_write) state <= st_wr;
                    else if (fifo_full) state <= st_stall;     // no room for the first byte
                    else                state <= st_rd;
                end
                st_wr: if (byte_end) begin
                    tail  <= 1'b1;
                    state <= st_stall;
                end
                st_rd: if (byte_end) begin
                    if (bytes_left == burst_len_w'(1)) begin
                        tail  <= 1'b1;
                        state <= st_stall;
                    end else if (fifo_full) begin
                        state <= st_stall;                     // wait at the byte boundary
                    end
                end
                st_stall: begin                                // spi_clk low, cs still low
                    if (tail) begin
                        tail      <= 1'b0;
                        xfer_done <= 1'b1;
                        state     <= st_idle;
                    end else if (!fifo_full) begin
                        state <= st_rd;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // shift registers, changed on falling edges and sampled on rising edges
    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_start) begin
            shift_out  <= is_write ? {1'b0, wr_addr} : {1'b1, rd_addr};  // command byte
            wr_hold    <= wr_data;
            bytes_left <= rd_count;
        end else if (byte_end) begin
            shift_out <= (state == st_cmd && done_was_write) ? wr_hold : '0;
            if (state == st_rd)
                bytes_left <= bytes_left - 1'b1;
        end else if (fall) begin
            shift_out <= {shift_out[spi_byte_w-2:0], 1'b0};
        end
        if (rise)
            shift_in <= {shift_in[spi_byte_w-2:0], serial_in};
    end

    // received byte, kept through soft reset for the status view
    always_ff @(posedge clk) begin
        if (reset)
            rx_byte <= '0;
        else if (last_rise)
            rx_byte <= {shift_in[spi_byte_w-2:0], serial_in};
    end

endmodule

`default_nettype wire

//--- source/spi_rx_fifo.sv
// spi_rx_fifo: first-word-fall-through byte fifo with occupancy count, full and empty flags
`timescale 1ns/1ps
`default_nettype none

module spi_rx_fifo (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                soft_clear,
    input  logic                                rx_push,
    input  logic [spi_ctrl_pkg::spi_byte_w-1:0] rx_byte,
    input  logic                                fifo_rd_en,
    output logic [spi_ctrl_pkg::spi_byte_w-1:0] fifo_dout,
    output logic                                fifo_not_empty,
    output logic                                fifo_full
);
    import spi_ctrl_pkg::*;

    logic [spi_byte_w-1:0] mem [rx_fifo_depth];
    logic [rx_fifo_aw-1:0] wr_ptr;
    logic [rx_fifo_aw-1:0] rd_ptr;
    logic [rx_fifo_aw:0]   count;   // one extra bit to tell full from empty
    logic                  pop;

    assign pop            = fifo_rd_en && fifo_not_empty;  // pop on empty is ignored
    assign fifo_not_empty = count != '0;
    assign fifo_full      = count == (rx_fifo_aw + 1)'(rx_fifo_depth);
    assign fifo_dout      = mem[rd_ptr];                   // head shown without latency

    // pointers and count, the engine never pushes while full
    always_ff @(posedge clk) begin
        if (reset || soft_clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rx_push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)     rd_ptr <= rd_ptr + 1'b1;
            case ({rx_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (rx_push)
            mem[wr_ptr] <= rx_byte;
    end

endmodule

`default_nettype wire

//--- source/spi_ctrl_top.sv
// spi_ctrl_top: apb register block, spi transaction engine and receive fifo
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [spi_ctrl_pkg::apb_addr_w-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [spi_ctrl_pkg::apb_data_w-1:0] pwdata,
    output logic [spi_ctrl_pkg::apb_data_w-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                spi_cs_n,
    output logic                                spi_clk,
    output logic                                serial_out,
    input  logic                                serial_in,
    input  logic                                fifo_rd_en,
    output logic [spi_ctrl_pkg::spi_byte_w-1:0] fifo_dout,
    output logic                                fifo_not_empty,
    output logic                                fifo_full,
    output logic                                write_complete,
    output logic                                read_complete
);
    import spi_ctrl_pkg::*;

    // register block to engine
    logic                   cmd_start;
    logic                   soft_clear;   // also empties the fifo
    logic                   is_write;
    logic [chip_addr_w-1:0] wr_addr;
    logic [spi_byte_w-1:0]  wr_data;
    logic [chip_addr_w-1:0] rd_addr;
    logic [burst_len_w-1:0] rd_count;
    // engine back to register block and fifo
    logic                   busy;
    logic                   xfer_done;
    logic                   done_was_write;
    logic [spi_byte_w-1:0]  last_rx_byte;
    logic                   rx_push;
    logic [spi_byte_w-1:0]  rx_byte;

    spi_apb_regs i_regs (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .busy, .xfer_done, .done_was_write, .last_rx_byte,
        .cmd_start, .soft_clear, .is_write, .wr_addr, .wr_data, .rd_addr, .rd_count,
        .write_complete, .read_complete
    );

    spi_xfer_engine i_engine (
        .clk, .reset, .soft_clear, .cmd_start, .is_write,
        .wr_addr, .wr_data, .rd_addr, .rd_count, .fifo_full, .serial_in,
        .busy, .xfer_done, .done_was_write, .last_rx_byte, .rx_push, .rx_byte,
        .spi_cs_n, .spi_clk, .serial_out
    );

    spi_rx_fifo i_fifo (
        .clk, .reset, .soft_clear, .rx_push, .rx_byte, .fifo_rd_en,
        .fifo_dout, .fifo_not_empty, .fifo_full
    );

endmodule

`default_nettype wire

//--- verification/spi_chip_model.sv
// spi_chip_model: mode 0 spi slave with a 128-byte register file, single writes and burst reads
`timescale 1ns/1ps
`default_nettype none

module spi_chip_model (
    input  logic spi_cs_n,
    input  logic spi_clk,
    input  logic serial_out,  // controller to chip
    output logic serial_in    // chip to controller
);
    logic [7:0] regs [128];
    logic [7:0] rx_sh;
    logic [7:0] tx_sh    = '0;
    logic [6:0] addr     = '0;
    logic [2:0] bit_cnt  = '0;    // bits of the current byte seen so far
    logic       have_cmd = 1'b0;  // command byte of this frame decoded
    logic       rd_mode  = 1'b0;

    initial begin
        for (int a = 0; a < 128; a++)
            regs[a] = 8'(a) ^ 8'h5a;  // power-up pattern
    end

    // sample on rising spi_clk, chip select going high ends the frame
    always @(posedge spi_clk or posedge spi_cs_n) begin
        if (spi_cs_n) begin
            bit_cnt  <= '0;
            have_cmd <= 1'b0;
        end else begin
            rx_sh   <= {rx_sh[6:0], serial_out};
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                if (!have_cmd) begin
                    have_cmd <= 1'b1;
                    rd_mode  <= rx_sh[6];                  // command bit 7
                    addr     <= {rx_sh[5:0], serial_out};
                end else if (rd_mode) begin
                    addr <= addr + 7'd1;                   // auto increment, wraps past 127
                end else begin
                    regs[addr] <= {rx_sh[6:0], serial_out};
                end
            end
        end
    end

    // drive on falling spi_clk, next register loaded at each byte boundary
    always @(negedge spi_clk) begin
        if (!spi_cs_n && have_cmd && rd_mode)
            tx_sh <= (bit_cnt == 3'd0) ? regs[addr] : {tx_sh[6:0], 1'b0};
    end

    assign serial_in = !spi_cs_n && have_cmd && rd_mode && tx_sh[7];  // msb first

endmodule

`default_nettype wire

//--- verification/spi_ctrl_properties.sv
// spi_ctrl_properties: concurrent checks on spi pins, fifo pushes, apb ready and the fifo head
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_properties (
    input logic                                clk,
    input logic                                reset,
    input logic                                psel,
    input logic                                penable,
    input logic                                pready,
    input logic                                spi_cs_n,
    input logic                                spi_clk,
    input logic                                rx_push,     // engine to fifo, internal
    input logic                                soft_clear,  // internal, moves the read pointer
    input logic                                fifo_rd_en,
    input logic                                fifo_not_empty,
    input logic                                fifo_full,
    input logic [spi_ctrl_pkg::spi_byte_w-1:0] fifo_dout
);
    // spi_clk only toggles inside a frame
    a_clk_idle: assert property (@(posedge clk) disable iff (reset) spi_cs_n |-> !spi_clk)
        else $error("spi_clk high while spi_cs_n is high");

    a_no_push_full: assert property (@(posedge clk) disable iff (reset) rx_push |-> !fifo_full)
        else $error("rx_push while fifo_full");

    // zero wait state slave
    a_ready: assert property (@(posedge clk) disable iff (reset) pready |-> psel && penable)
        else $error("pready outside an apb access phase");

    // head held until popped
    a_head_stable: assert property (@(posedge clk) disable iff (reset)
        fifo_not_empty && !fifo_rd_en && !soft_clear |=> $stable(fifo_dout))
        else $error("fifo_dout changed without a pop");

endmodule

bind spi_ctrl_top spi_ctrl_properties i_props (
    .clk, .reset, .psel, .penable, .pready, .spi_cs_n, .spi_clk, .rx_push, .soft_clear,
    .fifo_rd_en, .fifo_not_empty, .fifo_full, .fifo_dout
);

`default_nettype wire

//--- verification/spi_ctrl_tb.sv
// spi_ctrl_tb: clock, reset, apb tasks, chip memory copy, six directed tests and the summary
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl_tb;
    import spi_ctrl_pkg::*;

    localparam int wait_limit = 2000;  // clocks allowed for any single wait

    typedef enum int {ev_write_done, ev_read_done, ev_fifo_full, ev_fifo_data, ev_cs_idle} ev_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [apb_addr_w-1:0] paddr;
    logic [apb_data_w-1:0] pwdata, prdata;
    logic                  psel, penable, pwrite, pready, pslverr;
    logic                  spi_cs_n, spi_clk, serial_out, serial_in;
    logic                  fifo_rd_en, fifo_not_empty, fifo_full;
    logic [spi_byte_w-1:0] fifo_dout;
    logic                  write_complete, read_complete;

    logic [7:0]  ref_mem [128];  // what the chip should hold
    integer      seed = 32'h8f0e;
    int          test_errors = 0;
    int          errors = 0;
    int          tests_failed = 0;
    logic        apb_err;        // pslverr of the last access
    logic [31:0] apb_rdata;

    spi_ctrl_top i_dut (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .spi_cs_n, .spi_clk, .serial_out, .serial_in,
        .fifo_rd_en, .fifo_dout, .fifo_not_empty, .fifo_full, .write_complete, .read_complete
    );

    spi_chip_model i_chip (.spi_cs_n, .spi_clk, .serial_out, .serial_in);

    initial begin
        forever #4 clk = ~clk;  // 8 ns period
    end

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            test_errors++;
        end
    endtask

    // one setup and one access phase, results sampled mid access
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data);
        int n = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (!pready && n < wait_limit);
        if (!pready)
            abort_on_timeout("pready");
        apb_err   = pslverr;
        apb_rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_for(input ev_t ev, input string what);
        int   n = 0;
        logic hit = 1'b0;
        while (!hit && n < wait_limit) begin
            @(negedge clk);
            n++;
            case (ev)
                ev_write_done: hit = write_complete;
                ev_read_done:  hit = read_complete;
                ev_fifo_full:  hit = fifo_full;
                ev_fifo_data:  hit = fifo_not_empty;
                default:       hit = spi_cs_n;
            endcase
        end
        if (!hit)
            abort_on_timeout(what);
    endtask

    // compare the head, then pop it with a one-cycle rd_en
    task automatic pop_check(input logic [7:0] exp);
        wait_for(ev_fifo_data, "fifo_not_empty");
        check_eq("fifo_dout", 32'(fifo_dout), 32'(exp));
        @(posedge clk);
        fifo_rd_en <= 1'b1;
        @(posedge clk);
        fifo_rd_en <= 1'b0;
    endtask

    task automatic start_write(input logic [6:0] addr, input logic [7:0] data);
        apb_access(1'b1, reg_write_off, {17'd0, addr, data});
        apb_access(1'b1, reg_ctrl_off, 32'h3);  // is_write and start
        check_eq("pslverr", 32'(apb_err), 32'd0);
        ref_mem[addr] = data;
    endtask

    task automatic start_read(input logic [6:0] addr, input int count);
        apb_access(1'b1, reg_read_off, {16'd0, 8'(count), 1'b0, addr});
        apb_access(1'b1, reg_ctrl_off, 32'h2);  // start only, so a read
        check_eq("pslverr", 32'(apb_err), 32'd0);
    endtask

    // short bursts fit the fifo, so completion comes before draining
    task automatic read_bytes(input logic [6:0] addr, input int count);
        start_read(addr, count);
        wait_for(ev_read_done, "read_complete");
        for (int i = 0; i < count; i++)
            pop_check(ref_mem[addr + 7'(i)]);
    endtask

    task automatic finish_test(input int num, input string name);
        if (test_errors == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        logic [7:0] data;
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        fifo_rd_en = 1'b0;
        for (int a = 0; a < 128; a++)
            ref_mem[a] = 8'(a) ^ 8'h5a;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_eq("spi_cs_n", 32'(spi_cs_n), 32'd1);
        check_eq("fifo_not_empty", 32'(fifo_not_empty), 32'd0);
        check_eq("fifo_full", 32'(fifo_full), 32'd0);
        check_eq("write_complete", 32'(write_complete), 32'd0);
        check_eq("read_complete", 32'(read_complete), 32'd0);
        apb_access(1'b0, reg_status_off, 32'd0);
        check_eq("status", apb_rdata, 32'd0);
        finish_test(1, "reset state");

        data = 8'($random(seed));
        start_write(7'h12, data);
        wait_for(ev_write_done, "write_complete");
        apb_access(1'b0, reg_status_off, 32'd0);
        check_eq("status busy", 32'(apb_rdata[10]), 32'd0);
        check_eq("status write_complete", 32'(apb_rdata[8]), 32'd1);
        read_bytes(7'h12, 1);
        finish_test(2, "single write");

        read_bytes(7'h10, 4);
        apb_access(1'b0, reg_status_off, 32'd0);
        check_eq("status last byte", 32'(apb_rdata[7:0]), 32'(ref_mem[7'h13]));
        finish_test(3, "burst read");

        start_read(7'h78, 20);  // runs past 0x7f into 0x00
        wait_for(ev_fifo_full, "fifo_full");
        repeat (64) begin       // two byte times of held back-pressure
            @(negedge clk);
            check_eq("fifo_full", 32'(fifo_full), 32'd1);
            check_eq("read_complete", 32'(read_complete), 32'd0);
            check_eq("spi_clk", 32'(spi_clk), 32'd0);
        end
        for (int i = 0; i < 20; i++)
            pop_check(ref_mem[7'h78 + 7'(i)]);
        wait_for(ev_read_done, "read_complete");
        finish_test(4, "back-pressure");

        apb_access(1'b1, 4'hd, 32'd0);  // first offset past STATUS
        check_eq("pslverr", 32'(apb_err), 32'd1);
        apb_access(1'b1, reg_status_off, 32'd0);
        check_eq("pslverr", 32'(apb_err), 32'd1);
        data = 8'($random(seed));
        start_write(7'h33, data);
        apb_access(1'b1, reg_write_off, {17'd0, 7'h33, ~data});
        apb_access(1'b1, reg_ctrl_off, 32'h3);  // refused, engine busy
        check_eq("pslverr", 32'(apb_err), 32'd1);
        wait_for(ev_write_done, "write_complete");
        read_bytes(7'h33, 1);  // chip holds the data of the first start
        finish_test(5, "apb errors");

        start_read(7'h40, 10);
        wait_for(ev_fifo_data, "first burst byte");
        apb_access(1'b1, reg_ctrl_off, 32'h4);
        wait_for(ev_cs_idle, "spi_cs_n high after soft reset");
        check_eq("fifo_not_empty", 32'(fifo_not_empty), 32'd0);
        apb_access(1'b0, reg_status_off, 32'd0);
        check_eq("status busy", 32'(apb_rdata[10]), 32'd0);
        data = 8'($random(seed));
        start_write(7'h41, data);
        wait_for(ev_write_done, "write_complete");
        read_bytes(7'h41, 1);
        finish_test(6, "soft reset");

        $display("tests run 6, tests failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/spi_ctrl_pkg.sv
source/spi_apb_regs.sv
source/spi_xfer_engine.sv
source/spi_rx_fifo.sv
source/spi_ctrl_top.sv
verification/spi_chip_model.sv
verification/spi_ctrl_properties.sv
verification/spi_ctrl_tb.sv

//--- Makefile
# Verilator flow for the SPI command controller
TOP = spi_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
